//--- list.f
rtl/lsu_pkg.sv
rtl/lsu_addr_gen.sv
rtl/lsu_store_format.sv
rtl/lsu_pending_queue.sv
rtl/lsu_load_format.sv
rtl/lsu_skid_buffer.sv
rtl/lsu_unit.sv
tests/lsu_mem_model.sv
tests/lsu_unit_tb.sv

//--- rtl/lsu_addr_gen.sv
`timescale 1ns/1ps

module lsu_addr_gen import lsu_pkg::*; (
    input  lsu_req_t                     req,
    output lane_mask_t                   mem_mask,
    output word_addr_t [num_threads-1:0] word_addr,
    output byte_off_t [num_threads-1:0]  byte_off,
    output logic                         is_dup
);

    word_t [num_threads-1:0] full_addr;
    logic [num_threads-2:0]  addr_match;

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        assign full_addr[i] = req.base_addr[i] + req.offset;
        assign word_addr[i] = full_addr[i][31:2];
        assign byte_off[i]  = full_addr[i][1:0];
    end

    // inactive lanes never break a match
    for (genvar i = 1; i < num_threads; i++) begin : g_match
        assign addr_match[i-1] = ~req.tmask[i] || (req.base_addr[i] == req.base_addr[0]);
    end

    assign is_dup = req.tmask[0] && (&addr_match);

    // one access on lane 0 serves the whole warp
    assign mem_mask = is_dup ? lane_mask_t'(1) : req.tmask;

endmodule

//--- rtl/lsu_load_format.sv
`timescale 1ns/1ps

module lsu_load_format import lsu_pkg::*; (
    input  pend_entry_t entry,
    input  mem_rsp_t    rsp,
    output commit_t     commit
);

    word_t [num_threads-1:0] lane_data;

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        word_t       data32;
        logic [15:0] data16;
        logic [7:0]  data8;

        // duplicate access only fetched lane 0
        assign data32 = entry.is_dup ? rsp.data[0] : rsp.data[i];
        assign data16 = entry.byte_off[i][1] ? data32[31:16] : data32[15:0];
        assign data8  = entry.byte_off[i][0] ? data16[15:8] : data16[7:0];

        always_comb begin
            case (entry.fmt)
                fmt_b:   lane_data[i] = {{24{data8[7]}}, data8};
                fmt_h:   lane_data[i] = {{16{data16[15]}}, data16};
                fmt_bu:  lane_data[i] = {24'b0, data8};
                fmt_hu:  lane_data[i] = {16'b0, data16};
                fmt_w:   lane_data[i] = data32;
                default: lane_data[i] = data32;
            endcase
        end
    end

    always_comb begin
        commit.wid   = entry.wid;
        commit.tmask = entry.tmask;
        commit.pc    = entry.pc;
        commit.rd    = entry.rd;
        commit.wb    = 1'b1;
        commit.data  = lane_data;
    end

endmodule

//--- rtl/lsu_pending_queue.sv
`timescale 1ns/1ps

module lsu_pending_queue import lsu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        push,
    input  pend_entry_t push_entry,
    input  logic        pop,
    output pend_entry_t head,
    output logic        empty,
    output logic        full
);

    pend_entry_t entries [pend_depth];

    logic [$clog2(pend_depth)-1:0] wr_ptr;
    logic [$clog2(pend_depth)-1:0] rd_ptr;
    logic [$clog2(pend_depth):0]   count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == pend_depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == pend_depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    assign head  = entries[rd_ptr];
    assign empty = (count == 0);
    assign full  = (count == pend_depth);

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> !full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) pop |-> !empty
    );

endmodule

//--- rtl/lsu_pkg.sv
package lsu_pkg;

    localparam int num_threads = 4;
    localparam int num_warps   = 4;
    localparam int pend_depth  = 4;

    typedef logic [31:0]                  word_t;
    typedef logic [29:0]                  word_addr_t;
    typedef logic [num_threads-1:0]       lane_mask_t;
    typedef logic [3:0]                   byteen_t;
    typedef logic [1:0]                   byte_off_t;
    typedef logic [$clog2(num_warps)-1:0] wid_t;
    typedef logic [4:0]                   rd_t;

    // funct3 encoding whose low two bits give the access size
    typedef enum logic [2:0] {
        fmt_b  = 3'd0,
        fmt_h  = 3'd1,
        fmt_w  = 3'd2,
        fmt_bu = 3'd4,
        fmt_hu = 3'd5
    } lsu_fmt_e;

    typedef struct packed {
        wid_t                         wid;
        lane_mask_t                   tmask;
        word_t                        pc;
        rd_t                          rd;
        lsu_fmt_e                     fmt;
        logic                         is_store;
        logic                         is_fence;
        word_t [num_threads-1:0]      base_addr;
        word_t                        offset;
        word_t [num_threads-1:0]      store_data;
    } lsu_req_t;

    typedef struct packed {
        logic                         rw;
        lane_mask_t                   mask;
        word_addr_t [num_threads-1:0] addr;
        byteen_t [num_threads-1:0]    byteen;
        word_t [num_threads-1:0]      data;
    } mem_req_t;

    typedef struct packed {
        word_t [num_threads-1:0]      data;
    } mem_rsp_t;

    typedef struct packed {
        wid_t                         wid;
        lane_mask_t                   tmask;
        word_t                        pc;
        rd_t                          rd;
        lsu_fmt_e                     fmt;
        byte_off_t [num_threads-1:0]  byte_off;
        logic                         is_dup;
    } pend_entry_t;

    typedef struct packed {
        wid_t                         wid;
        lane_mask_t                   tmask;
        word_t                        pc;
        rd_t                          rd;
        logic                         wb;
        word_t [num_threads-1:0]      data;
    } commit_t;

endpackage

//--- rtl/lsu_skid_buffer.sv
`timescale 1ns/1ps

module lsu_skid_buffer import lsu_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    valid_in,
    output logic    ready_in,
    input  commit_t data_in,
    output logic    valid_out,
    input  logic    ready_out,
    output commit_t data_out
);

    logic    skid_valid;
    commit_t skid_data;
    logic    out_free;

    assign out_free = !valid_out || ready_out;

    // only the spare register decides ready
    assign ready_in = !skid_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_free) begin
                if (skid_valid) begin
                    valid_out  <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    valid_out <= valid_in;
                end
            end else if (valid_in && ready_in) begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (ready_in) begin
            skid_data <= data_in;
        end
    end

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        valid_out && !ready_out |=> valid_out && $stable(data_out)
    );

endmodule

//--- rtl/lsu_store_format.sv
`timescale 1ns/1ps

module lsu_store_format import lsu_pkg::*; (
    input  lsu_fmt_e                    fmt,
    input  logic                        is_store,
    input  word_t [num_threads-1:0]     store_data,
    input  byte_off_t [num_threads-1:0] byte_off,
    output byteen_t [num_threads-1:0]   byteen,
    output word_t [num_threads-1:0]     data
);

    logic [1:0] st_size;

    assign st_size = 2'(fmt);

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        byte_off_t hi_off;

        // upper byte of a halfword
        assign hi_off = {byte_off[i][1], 1'b1};

        always_comb begin
            byteen[i] = '0;
            if (!is_store) begin
                byteen[i] = '1;
            end else begin
                case (st_size)
                    2'd0: begin
                        byteen[i][byte_off[i]] = 1'b1;
                    end
                    2'd1: begin
                        byteen[i][byte_off[i]] = 1'b1;
                        byteen[i][hi_off]      = 1'b1;
                    end
                    default: begin
                        byteen[i] = '1;
                    end
                endcase
            end
        end

        assign data[i] = store_data[i] << {byte_off[i], 3'b000};
    end

endmodule

//--- rtl/lsu_unit.sv
`timescale 1ns/1ps

module lsu_unit import lsu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     lsu_req_valid,
    input  lsu_req_t lsu_req,
    output logic     lsu_req_ready,

    output logic     mem_req_valid,
    output mem_req_t mem_req,
    input  logic     mem_req_ready,

    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp,
    output logic     mem_rsp_ready,

    output logic     ld_commit_valid,
    output commit_t  ld_commit,
    input  logic     ld_commit_ready,

    output logic     st_commit_valid,
    output commit_t  st_commit
);

    lane_mask_t                   mem_mask;
    word_addr_t [num_threads-1:0] word_addr;
    byte_off_t [num_threads-1:0]  byte_off;
    logic                         is_dup;
    byteen_t [num_threads-1:0]    st_byteen;
    word_t [num_threads-1:0]      st_data;

    pend_entry_t push_entry;
    pend_entry_t head;
    commit_t     rsp_commit;
    logic        pq_empty;
    logic        pq_full;
    logic        stall;
    logic        req_fire;
    logic        rsp_fire;

    lsu_addr_gen addr_gen0 (
        .req       (lsu_req),
        .mem_mask  (mem_mask),
        .word_addr (word_addr),
        .byte_off  (byte_off),
        .is_dup    (is_dup)
    );

    lsu_store_format store_fmt0 (
        .fmt        (lsu_req.fmt),
        .is_store   (lsu_req.is_store),
        .store_data (lsu_req.store_data),
        .byte_off   (byte_off),
        .byteen     (st_byteen),
        .data       (st_data)
    );

    // fence waits for all loads in flight, loads wait for a free slot
    assign stall = (lsu_req.is_fence && !pq_empty) || (!lsu_req.is_store && pq_full);

    assign mem_req_valid = lsu_req_valid && !stall;
    assign lsu_req_ready = mem_req_ready && !stall;
    assign req_fire      = mem_req_valid && mem_req_ready;

    always_comb begin
        mem_req.rw     = lsu_req.is_store;
        mem_req.mask   = mem_mask;
        mem_req.addr   = word_addr;
        mem_req.byteen = st_byteen;
        mem_req.data   = st_data;
    end

    always_comb begin
        push_entry.wid      = lsu_req.wid;
        push_entry.tmask    = lsu_req.tmask;
        push_entry.pc       = lsu_req.pc;
        push_entry.rd       = lsu_req.rd;
        push_entry.fmt      = lsu_req.fmt;
        push_entry.byte_off = byte_off;
        push_entry.is_dup   = is_dup;
    end

    // stores retire as soon as they leave
    assign st_commit_valid = req_fire && lsu_req.is_store;

    always_comb begin
        st_commit.wid   = lsu_req.wid;
        st_commit.tmask = lsu_req.tmask;
        st_commit.pc    = lsu_req.pc;
        st_commit.rd    = '0;
        st_commit.wb    = 1'b0;
        st_commit.data  = '0;
    end

    assign rsp_fire = mem_rsp_valid && mem_rsp_ready;

    lsu_pending_queue pend_q0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (req_fire && !lsu_req.is_store),
        .push_entry (push_entry),
        .pop        (rsp_fire),
        .head       (head),
        .empty      (pq_empty),
        .full       (pq_full)
    );

    lsu_load_format load_fmt0 (
        .entry  (head),
        .rsp    (mem_rsp),
        .commit (rsp_commit)
    );

    lsu_skid_buffer ld_skid0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (mem_rsp_valid),
        .ready_in  (mem_rsp_ready),
        .data_in   (rsp_commit),
        .valid_out (ld_commit_valid),
        .ready_out (ld_commit_ready),
        .data_out  (ld_commit)
    );

    // memory answers only loads that were sent
    a_rsp_has_entry: assert property (
        @(posedge clk) disable iff (!arst_n) mem_rsp_valid |-> !pq_empty
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_unit_tb -f list.f \
    --Mdir obj_dir -o lsu_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/lsu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tests/lsu_mem_model.sv
`timescale 1ns/1ps

module lsu_mem_model import lsu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  mem_req_t req,
    output logic     req_ready,
    output logic     rsp_valid,
    output mem_rsp_t rsp,
    input  logic     rsp_ready
);

    word_t    mem [256];
    mem_rsp_t rsp_q [$];
    int       due_q [$];
    int       cycle;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = word_t'(32'h5a5a_0000 ^ (i * 32'h0101_0101));
        end
    end

    assign req_ready = 1'b1;

    always @(posedge clk or negedge arst_n) begin : respond
        mem_rsp_t rd_data;
        if (!arst_n) begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
            cycle     <= 0;
            rsp_q.delete();
            due_q.delete();
        end else begin
            cycle <= cycle + 1;
            if (rsp_valid && rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(due_q.pop_front());
            end
            if (req_valid && req_ready) begin
                for (int i = 0; i < num_threads; i++) begin
                    // lanes outside the mask read back garbage
                    rd_data.data[i] = 32'hdead_beef;
                    if (req.mask[i]) begin
                        if (req.rw) begin
                            for (int b = 0; b < 4; b++) begin
                                if (req.byteen[i][b]) begin
                                    mem[req.addr[i][7:0]][8*b +: 8] = req.data[i][8*b +: 8];
                                end
                            end
                        end else begin
                            rd_data.data[i] = mem[req.addr[i][7:0]];
                        end
                    end
                end
                if (!req.rw) begin
                    rsp_q.push_back(rd_data);
                    due_q.push_back(cycle + 1 + int'($urandom_range(7, 0)));
                end
            end
            if (rsp_q.size() > 0 && cycle >= due_q[0]) begin
                rsp_valid <= 1'b1;
                rsp       <= rsp_q[0];
            end else begin
                rsp_valid <= 1'b0;
            end
        end
    end

endmodule

//--- tests/lsu_unit_tb.sv
`timescale 1ns/1ps

module lsu_unit_tb import lsu_pkg::*; ();

    localparam int num_rows    = 24;
    localparam int cycle_limit = 60 * num_rows;

    typedef struct packed {
        lsu_req_t   req;
        lane_mask_t exp_mask;
        byteen_t    exp_be;
        word_t      exp_sdata;
        word_t      exp_ld;
    } row_t;

    logic     clk;
    logic     arst_n;
    logic     lsu_req_valid;
    lsu_req_t lsu_req;
    logic     lsu_req_ready;
    logic     mem_req_valid;
    mem_req_t mem_req;
    logic     mem_req_ready;
    logic     mem_rsp_valid;
    mem_rsp_t mem_rsp;
    logic     mem_rsp_ready;
    logic     ld_commit_valid;
    commit_t  ld_commit;
    logic     ld_commit_ready;
    logic     st_commit_valid;
    commit_t  st_commit;

    row_t    tbl [num_rows];
    commit_t exp_q [$];
    int      outstanding;
    int      cycles;

    lsu_unit dut0 (.*);

    lsu_mem_model mem0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (mem_req_valid),
        .req       (mem_req),
        .req_ready (mem_req_ready),
        .rsp_valid (mem_rsp_valid),
        .rsp       (mem_rsp),
        .rsp_ready (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input lane_mask_t got, input lane_mask_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_byteen(input string name, input byteen_t got, input byteen_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    // lane i gets base + i * stride and every lane stores the same data
    function automatic row_t row(input logic st, input logic fence, input lsu_fmt_e fmt,
                                 input lane_mask_t tmask, input word_t base, input int stride,
                                 input word_t off, input word_t data, input lane_mask_t exp_mask,
                                 input byteen_t exp_be, input word_t exp_sdata,
                                 input word_t exp_ld);
        row_t r;
        r = '0;
        r.req.is_store = st;
        r.req.is_fence = fence;
        r.req.fmt      = fmt;
        r.req.tmask    = tmask;
        r.req.offset   = off;
        for (int i = 0; i < num_threads; i++) begin
            r.req.base_addr[i]  = base + word_t'(i * stride);
            r.req.store_data[i] = data;
        end
        r.exp_mask  = exp_mask;
        r.exp_be    = exp_be;
        r.exp_sdata = exp_sdata;
        r.exp_ld    = exp_ld;
        return r;
    endfunction

    task automatic send(input row_t r, input int idx);
        lsu_req_t req;
        commit_t  e;
        req       = r.req;
        req.wid   = wid_t'(idx);
        req.pc    = word_t'(32'h1000 + 4 * idx);
        req.rd    = rd_t'(idx);
        lsu_req       <= req;
        lsu_req_valid <= 1'b1;
        forever begin
            @(posedge clk);
            if (req.is_fence && mem_req_valid && outstanding != 0) begin
                $display("fence request reached memory with %0d loads outstanding", outstanding);
                stop_run();
            end else if (lsu_req_ready) begin
                break;
            end
        end
        check_mask("mem_req.mask", mem_req.mask, r.exp_mask);
        for (int i = 0; i < num_threads; i++) begin
            check_byteen($sformatf("mem_req.byteen[%0d]", i), mem_req.byteen[i], r.exp_be);
            check_word($sformatf("mem_req.data[%0d]", i), mem_req.data[i], r.exp_sdata);
        end
        check_word("st_commit_valid", word_t'(st_commit_valid), word_t'(req.is_store));
        if (req.is_store) begin
            check_word("st_commit.pc", st_commit.pc, req.pc);
            check_word("st_commit.wid", word_t'(st_commit.wid), word_t'(req.wid));
            check_mask("st_commit.tmask", st_commit.tmask, req.tmask);
            check_word("st_commit.wb", word_t'(st_commit.wb), 32'h0);
            for (int i = 0; i < num_threads; i++) begin
                check_word($sformatf("st_commit.data[%0d]", i), st_commit.data[i], 32'h0);
            end
        end else begin
            e.wid   = req.wid;
            e.tmask = req.tmask;
            e.pc    = req.pc;
            e.rd    = req.rd;
            e.wb    = 1'b1;
            for (int i = 0; i < num_threads; i++) begin
                e.data[i] = r.exp_ld;
            end
            exp_q.push_back(e);
        end
    endtask

    // outstanding loads and in-order commit check
    always @(posedge clk) begin : monitor
        commit_t e;
        logic    ld_fire;
        logic    rsp_fire;
        ld_fire  = mem_req_valid && mem_req_ready && !mem_req.rw;
        rsp_fire = mem_rsp_valid && mem_rsp_ready;
        outstanding <= outstanding + int'(ld_fire) - int'(rsp_fire);
        if (arst_n && ld_commit_valid && ld_commit_ready) begin
            if (exp_q.size() == 0) begin
                $display("load commit arrived with no load waiting for one");
                stop_run();
            end else begin
                e = exp_q.pop_front();
                check_word("ld_commit.rd", word_t'(ld_commit.rd), word_t'(e.rd));
                check_word("ld_commit.pc", ld_commit.pc, e.pc);
                check_word("ld_commit.wid", word_t'(ld_commit.wid), word_t'(e.wid));
                check_mask("ld_commit.tmask", ld_commit.tmask, e.tmask);
                check_word("ld_commit.wb", word_t'(ld_commit.wb), 32'h1);
                for (int i = 0; i < num_threads; i++) begin
                    if (e.tmask[i]) begin
                        check_word($sformatf("ld_commit.data[%0d]", i), ld_commit.data[i],
                                   e.data[i]);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        ld_commit_ready <= ($urandom_range(9, 0) >= 3);
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            stop_run();
        end
    end

    initial begin
        void'($urandom(32'hb09c_9781));
        arst_n          = 1'b0;
        lsu_req_valid   = 1'b0;
        lsu_req         = '0;
        ld_commit_ready = 1'b0;
        outstanding     = 0;
        cycles          = 0;

        tbl[0]  = row(1, 0, fmt_w,  4'hf, 32'h100, 4, 0, 32'h8765_43a1, 4'hf, 4'hf,
                      32'h8765_43a1, 0);
        tbl[1]  = row(0, 0, fmt_b,  4'hf, 32'h100, 4, 0, 0, 4'hf, 4'hf, 0, 32'hffff_ffa1);
        tbl[2]  = row(0, 0, fmt_bu, 4'hf, 32'h100, 4, 1, 0, 4'hf, 4'hf, 0, 32'h0000_0043);
        tbl[3]  = row(0, 0, fmt_h,  4'hf, 32'h100, 4, 2, 0, 4'hf, 4'hf, 0, 32'hffff_8765);
        tbl[4]  = row(0, 0, fmt_hu, 4'hf, 32'h100, 4, 0, 0, 4'hf, 4'hf, 0, 32'h0000_43a1);
        tbl[5]  = row(0, 0, fmt_w,  4'hf, 32'h100, 4, 0, 0, 4'hf, 4'hf, 0, 32'h8765_43a1);
        tbl[6]  = row(1, 0, fmt_w,  4'hf, 32'h200, 4, 0, 0, 4'hf, 4'hf, 0, 0);
        tbl[7]  = row(1, 0, fmt_b,  4'hf, 32'h200, 4, 0, 32'h11, 4'hf, 4'h1, 32'h11, 0);
        tbl[8]  = row(1, 0, fmt_b,  4'hf, 32'h200, 4, 1, 32'h22, 4'hf, 4'h2, 32'h2200, 0);
        tbl[9]  = row(1, 0, fmt_b,  4'hf, 32'h200, 4, 2, 32'h33, 4'hf, 4'h4, 32'h0033_0000, 0);
        tbl[10] = row(1, 0, fmt_b,  4'hf, 32'h200, 4, 3, 32'h94, 4'hf, 4'h8, 32'h9400_0000, 0);
        tbl[11] = row(0, 0, fmt_w,  4'hf, 32'h200, 4, 0, 0, 4'hf, 4'hf, 0, 32'h9433_2211);
        tbl[12] = row(0, 0, fmt_b,  4'hf, 32'h200, 4, 3, 0, 4'hf, 4'hf, 0, 32'hffff_ff94);
        tbl[13] = row(1, 0, fmt_h,  4'hf, 32'h200, 4, 2, 32'hbeef, 4'hf, 4'hc, 32'hbeef_0000, 0);
        tbl[14] = row(1, 0, fmt_h,  4'hf, 32'h200, 4, 0, 32'h7001, 4'hf, 4'h3, 32'h7001, 0);
        tbl[15] = row(0, 0, fmt_h,  4'hf, 32'h200, 4, 2, 0, 4'hf, 4'hf, 0, 32'hffff_beef);
        tbl[16] = row(0, 0, fmt_hu, 4'hf, 32'h200, 4, 2, 0, 4'hf, 4'hf, 0, 32'h0000_beef);
        tbl[17] = row(0, 0, fmt_b,  4'hf, 32'h200, 4, 1, 0, 4'hf, 4'hf, 0, 32'h0000_0070);
        // lane 0 alone goes to memory when every lane shares one base
        tbl[18] = row(1, 0, fmt_w,  4'hf, 32'h300, 0, 0, 32'h1234_5678, 4'h1, 4'hf,
                      32'h1234_5678, 0);
        tbl[19] = row(0, 0, fmt_w,  4'hf, 32'h300, 0, 0, 0, 4'h1, 4'hf, 0, 32'h1234_5678);
        tbl[20] = row(0, 0, fmt_h,  4'hb, 32'h300, 0, 2, 0, 4'h1, 4'hf, 0, 32'h0000_1234);
        tbl[21] = row(0, 0, fmt_w,  4'h6, 32'h100, 4, 0, 0, 4'h6, 4'hf, 0, 32'h8765_43a1);
        tbl[22] = row(0, 0, fmt_bu, 4'hf, 32'h200, 4, 0, 0, 4'hf, 4'hf, 0, 32'h0000_0001);
        tbl[23] = row(0, 1, fmt_w,  4'hf, 32'h200, 4, 0, 0, 4'hf, 4'hf, 0, 32'hbeef_7001);

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        for (int idx = 0; idx < num_rows; idx++) begin
            send(tbl[idx], idx);
        end
        lsu_req_valid <= 1'b0;

        while (exp_q.size() != 0 || outstanding != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule
